//--- project.f
core_pkg.sv
inst_fetch.sv
fetch_buffer.sv
inst_decode.sv
core_frontend.sv
tb_checker.sv
tb_core_frontend.sv

//--- run.sh
#!/bin/sh
# build and run the front-end testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f project.f --top-module tb_core_frontend -o sim_frontend
./obj_dir/sim_frontend > sim.log 2>&1
cat sim.log

if grep -q "Simulation finished: PASS" sim.log; then
  exit 0
fi
exit 1

//--- tb_core_frontend.sv
// ----------------------------------------------------------------------
// testbench for the front end with reset_pc 0 and fb_depth 8
// the cache model answers only inside the table, one idle cycle per line
// ----------------------------------------------------------------------

`timescale 1ns/1ps

module tb_core_frontend import core_pkg::*; ();

  localparam int n_rows       = 16;
  localparam int hold_start   = 8;
  localparam int hold_end     = 22;
  localparam int wait_limit   = 400;
  localparam int drain_cycles = 12;

  logic                  clock             = 1'b0;
  logic                  reset             = 1'b1;
  logic [line_width-1:0] icache_data       = '0;
  logic                  icache_data_valid = 1'b0;
  logic                  backend_full      = 1'b0;
  logic [xlen-1:0]       icache_addr;
  logic                  uop_valid;
  logic [xlen-1:0]       uop_pc;
  uop_class_e            uop_class;
  logic [4:0]            uop_rd;
  logic                  uop_rd_valid;
  logic [4:0]            uop_rs1;
  logic [4:0]            uop_rs2;
  logic [xlen-1:0]       uop_imm;

  // stimulus table, the expected pc of a row is 4 times its index
  logic [xlen-1:0] tbl_word     [n_rows];
  uop_class_e      exp_class    [n_rows];
  logic [4:0]      exp_rd       [n_rows];
  logic            exp_rd_valid [n_rows];
  logic [4:0]      exp_rs1      [n_rows];
  logic [4:0]      exp_rs2      [n_rows];
  logic [xlen-1:0] exp_imm      [n_rows];

  int seed = 32'h8abc;
  int cycle;
  int burst_left;
  int rows_seen;
  int tests_passed;
  int tests_failed;
  int error_count;

  always #2 clock = ~clock;

  core_frontend #(
    .reset_pc ('0),
    .fb_depth (8)
  ) uut (
    .clock             (clock            ),
    .reset             (reset            ),
    .icache_addr       (icache_addr      ),
    .icache_data       (icache_data      ),
    .icache_data_valid (icache_data_valid),
    .backend_full      (backend_full     ),
    .uop_valid         (uop_valid        ),
    .uop_pc            (uop_pc           ),
    .uop_class         (uop_class        ),
    .uop_rd            (uop_rd           ),
    .uop_rd_valid      (uop_rd_valid     ),
    .uop_rs1           (uop_rs1          ),
    .uop_rs2           (uop_rs2          ),
    .uop_imm           (uop_imm          )
  );

  tb_checker #(
    .n_rows (n_rows)
  ) chk (
    .clock        (clock       ),
    .reset        (reset       ),
    .backend_full (backend_full),
    .icache_addr  (icache_addr ),
    .uop_valid    (uop_valid   ),
    .uop_pc       (uop_pc      ),
    .uop_class    (uop_class   ),
    .uop_rd       (uop_rd      ),
    .uop_rd_valid (uop_rd_valid),
    .uop_rs1      (uop_rs1     ),
    .uop_rs2      (uop_rs2     ),
    .uop_imm      (uop_imm     ),
    .exp_class    (exp_class   ),
    .exp_rd       (exp_rd      ),
    .exp_rd_valid (exp_rd_valid),
    .exp_rs1      (exp_rs1     ),
    .exp_rs2      (exp_rs2     ),
    .exp_imm      (exp_imm     ),
    .rows_seen    (rows_seen   ),
    .tests_passed (tests_passed),
    .tests_failed (tests_failed),
    .error_count  (error_count )
  );

  task automatic set_row(input int i, input logic [xlen-1:0] word, input uop_class_e cls,
                         input logic [4:0] rd, input logic rdv, input logic [4:0] rs1,
                         input logic [4:0] rs2, input logic [xlen-1:0] imm);
    tbl_word[i]     = word;
    exp_class[i]    = cls;
    exp_rd[i]       = rd;
    exp_rd_valid[i] = rdv;
    exp_rs1[i]      = rs1;
    exp_rs2[i]      = rs2;
    exp_imm[i]      = imm;
  endtask

  // four words from the table, lowest address in the low word
  function automatic logic [line_width-1:0] line_at(input logic [xlen-1:0] addr);
    logic [line_width-1:0] line;
    int                    idx;
    line = '0;
    for (int i = 0; i < fetch_width; i++) begin
      idx = int'(addr >> 2) + i;
      if (idx < n_rows)
        line[xlen*i +: xlen] = tbl_word[idx];
    end
    return line;
  endfunction

  // back-pressure by phases, cache gaps at random throughout
  always @(posedge clock) begin
    if (reset) begin
      cycle             <= 0;
      burst_left        <= 0;
      backend_full      <= 1'b0;
      icache_data_valid <= 1'b0;
    end else begin
      cycle <= cycle + 1;
      if (cycle >= hold_start && cycle < hold_end) begin
        // long stall, lets the buffer fill up
        backend_full <= 1'b1;
      end else if (burst_left != 0) begin
        backend_full <= 1'b1;
        burst_left   <= burst_left - 1;
      end else if (($random(seed) & 3) == 0) begin
        backend_full <= 1'b1;
        burst_left   <= $random(seed) & 3;
      end else begin
        backend_full <= 1'b0;
      end
      // idle after each offered line so the address seen here is settled
      if (icache_data_valid) begin
        icache_data_valid <= 1'b0;
      end else if (icache_addr < xlen'(n_rows * 4) && ($random(seed) & 3) != 0) begin
        icache_data_valid <= 1'b1;
        icache_data       <= line_at(icache_addr);
      end else begin
        icache_data_valid <= 1'b0;
      end
    end
  end

  initial begin
    int waited;
    // row, word, class, rd, rd_valid, rs1, rs2, imm
    set_row(0,  32'h003100b3, alu_reg, 5'd1,  1'b1, 5'd2,  5'd3,  32'h00000000);
    set_row(1,  32'h407302b3, alu_reg, 5'd5,  1'b1, 5'd6,  5'd7,  32'h00000000);
    set_row(2,  32'hffb58513, alu_imm, 5'd10, 1'b1, 5'd11, 5'd0,  32'hfffffffb);
    set_row(3,  32'h00000013, alu_imm, 5'd0,  1'b0, 5'd0,  5'd0,  32'h00000000);
    set_row(4,  32'h7ff47213, alu_imm, 5'd4,  1'b1, 5'd8,  5'd0,  32'h000007ff);
    set_row(5,  32'h01012603, load,    5'd12, 1'b1, 5'd2,  5'd0,  32'h00000010);
    set_row(6,  32'hfff18003, load,    5'd0,  1'b0, 5'd3,  5'd0,  32'hffffffff);
    set_row(7,  32'h00e7a423, store,   5'd0,  1'b0, 5'd15, 5'd14, 32'h00000008);
    set_row(8,  32'hfe112e23, store,   5'd0,  1'b0, 5'd2,  5'd1,  32'hfffffffc);
    set_row(9,  32'h00208863, branch,  5'd0,  1'b0, 5'd1,  5'd2,  32'h00000010);
    set_row(10, 32'hfe419ce3, branch,  5'd0,  1'b0, 5'd3,  5'd4,  32'hfffffff8);
    set_row(11, 32'h12345a37, lui,     5'd20, 1'b1, 5'd0,  5'd0,  32'h12345000);
    set_row(12, 32'hfffff037, lui,     5'd0,  1'b0, 5'd0,  5'd0,  32'hfffff000);
    set_row(13, 32'h001000ef, jal,     5'd1,  1'b1, 5'd0,  5'd0,  32'h00000800);
    set_row(14, 32'hffdff06f, jal,     5'd0,  1'b0, 5'd0,  5'd0,  32'hfffffffc);
    set_row(15, 32'hffffffff, illegal, 5'd0,  1'b0, 5'd0,  5'd0,  32'h00000000);
    repeat (3) @(posedge clock);
    reset <= 1'b0;
    waited = 0;
    while (rows_seen < n_rows && waited < wait_limit) begin
      @(negedge clock);
      waited++;
    end
    if (rows_seen < n_rows) begin
      $display("timeout: only %0d of %0d micro-ops decoded after %0d cycles",
               rows_seen, n_rows, waited);
      $display("Simulation finished: FAIL");
    end else begin
      // extra cycles to catch a duplicated micro-op
      repeat (drain_cycles) @(negedge clock);
      $display("tests passed %0d, failed %0d, errors %0d, micro-ops %0d",
               tests_passed, tests_failed, error_count, rows_seen);
      if (error_count == 0 && tests_failed == 0 && rows_seen == n_rows) begin
        $display("Simulation finished: PASS");
      end else begin
        $display("Simulation finished: FAIL");
      end
    end
    $finish;
  end

endmodule

//--- tb_checker.sv
// ----------------------------------------------------------------------
// watches the front end and compares each micro-op with the table
// expects reset_pc 0; rows must arrive in table order
// ----------------------------------------------------------------------

`timescale 1ns/1ps

module tb_checker import core_pkg::*; #(
  parameter int n_rows = 16
) (
  input  logic            clock,
  input  logic            reset,
  input  logic            backend_full,
  input  logic [xlen-1:0] icache_addr,
  input  logic            uop_valid,
  input  logic [xlen-1:0] uop_pc,
  input  uop_class_e      uop_class,
  input  logic [4:0]      uop_rd,
  input  logic            uop_rd_valid,
  input  logic [4:0]      uop_rs1,
  input  logic [4:0]      uop_rs2,
  input  logic [xlen-1:0] uop_imm,
  input  uop_class_e      exp_class [n_rows],
  input  logic [4:0]      exp_rd [n_rows],
  input  logic            exp_rd_valid [n_rows],
  input  logic [4:0]      exp_rs1 [n_rows],
  input  logic [4:0]      exp_rs2 [n_rows],
  input  logic [xlen-1:0] exp_imm [n_rows],
  output int              rows_seen,
  output int              tests_passed,
  output int              tests_failed,
  output int              error_count
);

  logic            first_cycle = 1'b0;
  logic            prev_full   = 1'b0;
  logic [xlen-1:0] prev_addr   = '0;

  task automatic check_value(input string where, input string name,
                             input logic [xlen-1:0] got, input logic [xlen-1:0] exp);
    if (got !== exp) begin
      $display("[FAIL] %s %s: got %h expected %h", where, name, got, exp);
      error_count++;
    end
  endtask

  task automatic close_test(input string what, input int errs_before);
    if (error_count == errs_before) begin
      $display("[PASS] %s", what);
      tests_passed++;
    end else begin
      $display("%s: failed", what);
      tests_failed++;
    end
  endtask

  task automatic compare_uop();
    string where;
    int    errs_before;
    int    r;
    errs_before = error_count;
    r           = rows_seen;
    where       = $sformatf("row %0d", r);
    if (r >= n_rows) begin
      $display("an extra micro-op at pc %h arrived after the last table row", uop_pc);
      error_count++;
    end else begin
      check_value(where, "uop_pc", uop_pc, xlen'(r * 4));
      check_value(where, "uop_class", xlen'(uop_class), xlen'(exp_class[r]));
      check_value(where, "uop_rd", xlen'(uop_rd), xlen'(exp_rd[r]));
      check_value(where, "uop_rd_valid", xlen'(uop_rd_valid), xlen'(exp_rd_valid[r]));
      check_value(where, "uop_rs1", xlen'(uop_rs1), xlen'(exp_rs1[r]));
      check_value(where, "uop_rs2", xlen'(uop_rs2), xlen'(exp_rs2[r]));
      check_value(where, "uop_imm", uop_imm, exp_imm[r]);
    end
    close_test($sformatf("%s pc %h", where, uop_pc), errs_before);
    rows_seen++;
  endtask

  always @(posedge clock) begin
    int errs_before;
    if (reset) begin
      rows_seen    = 0;
      tests_passed = 0;
      tests_failed = 0;
      error_count  = 0;
      first_cycle <= 1'b1;
      prev_full   <= 1'b0;
    end else begin
      if (first_cycle) begin
        errs_before = error_count;
        check_value("reset", "uop_valid", xlen'(uop_valid), '0);
        check_value("reset", "icache_addr", icache_addr, '0);
        close_test("reset state", errs_before);
      end else if (icache_addr != prev_addr && icache_addr != prev_addr + xlen'(16)) begin
        $display("[FAIL] icache_addr: got %h expected %h or %h",
                 icache_addr, prev_addr, prev_addr + xlen'(16));
        error_count++;
      end
      // a stall seen last cycle must already have stopped the micro-ops
      if (prev_full && uop_valid) begin
        $display("uop_valid was still high two cycles after backend_full went high");
        error_count++;
      end
      if (uop_valid)
        compare_uop();
      first_cycle <= 1'b0;
      prev_full   <= backend_full;
      prev_addr   <= icache_addr;
    end
  end

endmodule

//--- core_frontend.sv
// ----------------------------------------------------------------------
// in-order front end: fetch, fetch buffer and decode
// icache_data_valid means the data belongs to the current icache_addr
// ----------------------------------------------------------------------

`timescale 1ns/1ps

module core_frontend import core_pkg::*; #(
  parameter logic [xlen-1:0] reset_pc = '0,
  parameter int              fb_depth = 8
) (
  input  logic                  clock,
  input  logic                  reset,
  output logic [xlen-1:0]       icache_addr,
  input  logic [line_width-1:0] icache_data,
  input  logic                  icache_data_valid,
  input  logic                  backend_full,
  output logic                  uop_valid,
  output logic [xlen-1:0]       uop_pc,
  output uop_class_e            uop_class,
  output logic [4:0]            uop_rd,
  output logic                  uop_rd_valid,
  output logic [4:0]            uop_rs1,
  output logic [4:0]            uop_rs2,
  output logic [xlen-1:0]       uop_imm
);

  logic                        push;
  fb_entry_t [fetch_width-1:0] push_entries;
  logic                        fb_full;
  fb_entry_t                   head_entry;
  logic                        empty;
  logic                        pop;

  inst_fetch #(
    .reset_pc (reset_pc)
  ) if0 (
    .clock             (clock            ),
    .reset             (reset            ),
    .icache_data       (icache_data      ),
    .icache_data_valid (icache_data_valid),
    .fb_full           (fb_full          ),
    .icache_addr       (icache_addr      ),
    .push              (push             ),
    .push_entries      (push_entries     )
  );

  fetch_buffer #(
    .fb_depth (fb_depth)
  ) fb (
    .clock        (clock       ),
    .reset        (reset       ),
    .push         (push        ),
    .push_entries (push_entries),
    .pop          (pop         ),
    .head_entry   (head_entry  ),
    .empty        (empty       ),
    .fb_full      (fb_full     )
  );

  inst_decode id (
    .clock        (clock       ),
    .reset        (reset       ),
    .backend_full (backend_full),
    .head_entry   (head_entry  ),
    .empty        (empty       ),
    .pop          (pop         ),
    .uop_valid    (uop_valid   ),
    .uop_pc       (uop_pc      ),
    .uop_class    (uop_class   ),
    .uop_rd       (uop_rd      ),
    .uop_rd_valid (uop_rd_valid),
    .uop_rs1      (uop_rs1     ),
    .uop_rs2      (uop_rs2     ),
    .uop_imm      (uop_imm     )
  );

endmodule

//--- inst_decode.sv
// ----------------------------------------------------------------------
// single-issue RV32I decode, classification and immediates only
// unused register fields read as zero; outputs lag the pop by one cycle
// ----------------------------------------------------------------------

`timescale 1ns/1ps

module inst_decode import core_pkg::*; (
  input  logic            clock,
  input  logic            reset,
  input  logic            backend_full,
  input  fb_entry_t       head_entry,
  input  logic            empty,
  output logic            pop,
  output logic            uop_valid,
  output logic [xlen-1:0] uop_pc,
  output uop_class_e      uop_class,
  output logic [4:0]      uop_rd,
  output logic            uop_rd_valid,
  output logic [4:0]      uop_rs1,
  output logic [4:0]      uop_rs2,
  output logic [xlen-1:0] uop_imm
);

  inst_word_u      inst;
  uop_class_e      cls;
  logic            rd_used;
  logic            rs1_used;
  logic            rs2_used;
  logic [xlen-1:0] imm;

  assign inst = head_entry.inst;

  // take one instruction whenever the back end has room
  assign pop = ~empty & ~backend_full;

  always_comb begin
    cls      = illegal;
    rd_used  = 1'b0;
    rs1_used = 1'b0;
    rs2_used = 1'b0;
    imm      = '0;
    case (inst.r_type.opcode)
      7'b0110011: begin
        cls      = alu_reg;
        rd_used  = 1'b1;
        rs1_used = 1'b1;
        rs2_used = 1'b1;
      end
      7'b0010011: begin
        cls      = alu_imm;
        rd_used  = 1'b1;
        rs1_used = 1'b1;
        imm      = {{20{inst.i_type.imm[11]}}, inst.i_type.imm};
      end
      7'b0000011: begin
        cls      = load;
        rd_used  = 1'b1;
        rs1_used = 1'b1;
        imm      = {{20{inst.i_type.imm[11]}}, inst.i_type.imm};
      end
      7'b0100011: begin
        cls      = store;
        rs1_used = 1'b1;
        rs2_used = 1'b1;
        imm      = {{20{inst.s_type.imm_11_5[6]}}, inst.s_type.imm_11_5,
                    inst.s_type.imm_4_0};
      end
      7'b1100011: begin
        cls      = branch;
        rs1_used = 1'b1;
        rs2_used = 1'b1;
        imm      = {{19{inst.b_type.imm_12}}, inst.b_type.imm_12, inst.b_type.imm_11,
                    inst.b_type.imm_10_5, inst.b_type.imm_4_1, 1'b0};
      end
      7'b0110111: begin
        cls     = lui;
        rd_used = 1'b1;
        imm     = {inst.u_type.imm_31_12, 12'b0};
      end
      7'b1101111: begin
        cls     = jal;
        rd_used = 1'b1;
        imm     = {{11{inst.j_type.imm_20}}, inst.j_type.imm_20, inst.j_type.imm_19_12,
                   inst.j_type.imm_11, inst.j_type.imm_10_1, 1'b0};
      end
      // anything else stays illegal with no destination
      default: begin
        cls = illegal;
      end
    endcase
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      uop_valid <= 1'b0;
    end else begin
      uop_valid <= pop;
    end
  end

  // payload only moves on a pop, so it holds while stalled
  always_ff @(posedge clock) begin
    if (pop) begin
      uop_pc       <= head_entry.pc;
      uop_class    <= cls;
      uop_rd       <= rd_used ? inst.r_type.rd : 5'd0;
      uop_rd_valid <= rd_used & (inst.r_type.rd != 5'd0);
      uop_rs1      <= rs1_used ? inst.r_type.rs1 : 5'd0;
      uop_rs2      <= rs2_used ? inst.r_type.rs2 : 5'd0;
      uop_imm      <= imm;
    end
  end

endmodule

//--- fetch_buffer.sv
// ----------------------------------------------------------------------
// circular queue, four entries in and one entry out per cycle
// fb_depth must be a power of two of at least 8
// push must not be raised while fb_full is high, nor pop while empty
// ----------------------------------------------------------------------

`timescale 1ns/1ps

module fetch_buffer import core_pkg::*; #(
  parameter int fb_depth = 8
) (
  input  logic                        clock,
  input  logic                        reset,
  input  logic                        push,
  input  fb_entry_t [fetch_width-1:0] push_entries,
  input  logic                        pop,
  output fb_entry_t                   head_entry,
  output logic                        empty,
  output logic                        fb_full
);

  localparam int ptr_w = $clog2(fb_depth);
  localparam int cnt_w = ptr_w + 1;

  fb_entry_t        mem [fb_depth];
  logic [ptr_w-1:0] wr_ptr;
  logic [ptr_w-1:0] rd_ptr;
  logic [cnt_w-1:0] count;
  logic [cnt_w-1:0] push_cnt;
  logic [cnt_w-1:0] pop_cnt;

  assign push_cnt = push ? cnt_w'(fetch_width) : '0;
  assign pop_cnt  = pop ? cnt_w'(1) : '0;

  // pointers and occupancy
  always_ff @(posedge clock) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= wr_ptr + ptr_w'(fetch_width);
      end
      if (pop) begin
        rd_ptr <= rd_ptr + ptr_w'(1);
      end
      count <= count + push_cnt - pop_cnt;
    end
  end

  // a line lands in consecutive slots, wrapping at the end
  always_ff @(posedge clock) begin
    if (push) begin
      for (int i = 0; i < fetch_width; i++) begin
        mem[wr_ptr + ptr_w'(i)] <= push_entries[i];
      end
    end
  end

  assign head_entry = mem[rd_ptr];
  assign empty      = (count == '0);

  // full as soon as a whole line no longer fits
  assign fb_full = (count > cnt_w'(fb_depth - fetch_width));

endmodule

//--- inst_fetch.sv
// ----------------------------------------------------------------------
// sequential fetch only, no branch redirect
// reset_pc must be 16-byte aligned; the cache answers the current address
// ----------------------------------------------------------------------

`timescale 1ns/1ps

module inst_fetch import core_pkg::*; #(
  parameter logic [xlen-1:0] reset_pc = '0
) (
  input  logic                              clock,
  input  logic                              reset,
  input  logic [line_width-1:0]             icache_data,
  input  logic                              icache_data_valid,
  input  logic                              fb_full,
  output logic [xlen-1:0]                   icache_addr,
  output logic                              push,
  output fb_entry_t [fetch_width-1:0]       push_entries
);

  // bytes covered by one line
  localparam logic [xlen-1:0] line_bytes = xlen'(fetch_width * 4);

  // a line is taken only when the buffer can hold all of it
  assign push = icache_data_valid & ~fb_full;

  always_ff @(posedge clock) begin
    if (reset) begin
      icache_addr <= reset_pc;
    end else if (push) begin
      icache_addr <= icache_addr + line_bytes;
    end
  end

  // lowest word of the line is the lowest address
  always_comb begin
    for (int i = 0; i < fetch_width; i++) begin
      push_entries[i].pc   = icache_addr + xlen'(4 * i);
      push_entries[i].inst = icache_data[xlen*i +: xlen];
    end
  end

endmodule

//--- core_pkg.sv
// ----------------------------------------------------------------------
// shared types for the RV32I front end
// one cache line carries fetch_width instructions of xlen bits each
// ----------------------------------------------------------------------

package core_pkg;

  localparam int fetch_width = 4;
  localparam int xlen        = 32;
  localparam int line_width  = fetch_width * xlen;

  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    logic [6:0] opcode;
  } r_type_t;

  typedef struct packed {
    logic [11:0] imm;
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } i_type_t;

  typedef struct packed {
    logic [6:0] imm_11_5;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] imm_4_0;
    logic [6:0] opcode;
  } s_type_t;

  typedef struct packed {
    logic       imm_12;
    logic [5:0] imm_10_5;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [3:0] imm_4_1;
    logic       imm_11;
    logic [6:0] opcode;
  } b_type_t;

  typedef struct packed {
    logic [19:0] imm_31_12;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } u_type_t;

  typedef struct packed {
    logic       imm_20;
    logic [9:0] imm_10_1;
    logic       imm_11;
    logic [7:0] imm_19_12;
    logic [4:0] rd;
    logic [6:0] opcode;
  } j_type_t;

  // all views share the opcode in bits 6:0
  typedef union packed {
    r_type_t r_type;
    i_type_t i_type;
    s_type_t s_type;
    b_type_t b_type;
    u_type_t u_type;
    j_type_t j_type;
  } inst_word_u;

  typedef struct packed {
    logic [xlen-1:0] pc;
    inst_word_u      inst;
  } fb_entry_t;

  typedef enum logic [2:0] {
    alu_reg = 3'd0,
    alu_imm = 3'd1,
    load    = 3'd2,
    store   = 3'd3,
    branch  = 3'd4,
    lui     = 3'd5,
    jal     = 3'd6,
    illegal = 3'd7
  } uop_class_e;

endpackage
